/* rtl/fds_map_pkg.sv */
// disk system map package: CPU register addresses and PRG/CHR address constants
package fds_map_pkg;

	typedef logic [15:0]  addr_t;      // CPU address
	typedef logic [18:0]  prg_addr_t;  // physical PRG address
	typedef logic [18:10] chr_addr_t;  // physical CHR address, upper bits only

	// write registers
	localparam addr_t REG_TIMER_LO   = 16'h4020;
	localparam addr_t REG_TIMER_HI   = 16'h4021;
	localparam addr_t REG_TIMER_CTRL = 16'h4022;
	localparam addr_t REG_DISK_EN    = 16'h4023;
	localparam addr_t REG_DISK_CTRL  = 16'h4025;
	localparam addr_t REG_DISK_SIDE  = 16'h4027;  // extra side select register

	// read registers
	localparam addr_t REG_IRQ_STAT   = 16'h4030;
	localparam addr_t REG_DRIVE_STAT = 16'h4032;
	localparam addr_t REG_EXP_STAT   = 16'h4033;
	localparam addr_t REG_BUSY       = 16'h4029;
	localparam addr_t REG_SAVED      = 16'h4208;

	// BIOS disk data ports
	localparam addr_t PORT_READ_LO   = 16'h4CD0;
	localparam addr_t PORT_READ_HI   = 16'h4CD1;
	localparam addr_t PORT_WRITE_LO  = 16'h4CCD;
	localparam addr_t PORT_WRITE_HI  = 16'h4CCE;

	localparam logic [3:0] RAM_BANK_BASE = 4'b0001;  // work RAM at 08000-0FFFF

endpackage

/* rtl/fds_disk_pkg.sv */
// disk image package: side geometry, side offsets and port sequencer state
package fds_disk_pkg;

	typedef logic [15:0] disk_pos_t;
	typedef logic [17:0] disk_off_t;
	typedef logic [1:0]  side_t;

	localparam int SIDE_BYTES   = 65500;
	localparam int DISK_END     = 65499;  // last valid position on a side
	localparam int HEADER_BYTES = 16;     // image header ahead of side 0

	// read/write port sequencer
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ARMED,   // low port seen
		ST_ACTIVE   // low then high port seen, streaming
	} port_state_t;

	// start of a side within the image
	function automatic disk_off_t side_offset(side_t side);
		int unsigned off;
		off = HEADER_BYTES + side * SIDE_BYTES;
		return disk_off_t'(off);
	endfunction

endpackage

/* rtl/fds_reg_ctrl.sv */
// disk system register control: decodes CPU writes into disk state and timer load strobes
`timescale 1ns/1ps

module fds_reg_ctrl #(
	parameter int TIMER_W = 16
) (
	input  logic                clk20,
	input  logic                reset,
	input  logic                cpu_strobe,
	input  logic                cpu_we,
	input  fds_map_pkg::addr_t  cpu_addr,
	input  logic [7:0]          cpu_wdata,
	output logic                latch_lo_load,
	output logic                latch_hi_load,
	output logic                timer_ctrl_load,
	output logic                disk_en_load,
	output logic                disk_reg_en,
	output logic                disk_reset,
	output logic                write_en,
	output logic                vertical,
	output fds_disk_pkg::side_t disk_side
);
	import fds_map_pkg::*;

	logic wr_strobe;

	assign wr_strobe = cpu_strobe && cpu_we;

	// load strobes coincide with the bus strobe, the timer acts on the same edge
	assign latch_lo_load   = wr_strobe && (cpu_addr == REG_TIMER_LO);
	assign latch_hi_load   = wr_strobe && (cpu_addr == REG_TIMER_HI) && (TIMER_W > 8);
	assign timer_ctrl_load = wr_strobe && (cpu_addr == REG_TIMER_CTRL);
	assign disk_en_load    = wr_strobe && (cpu_addr == REG_DISK_EN);

	always_ff @(posedge clk20) begin
		if (reset) begin
			disk_reg_en <= 1'b0;
			disk_reset  <= 1'b0;
			write_en    <= 1'b0;
			vertical    <= 1'b0;
			disk_side   <= '0;
		end else if (wr_strobe) begin
			case (cpu_addr)
				REG_DISK_EN: begin
					disk_reg_en <= cpu_wdata[0];
				end
				REG_DISK_CTRL: begin
					disk_reset <= cpu_wdata[1];
					write_en   <= !cpu_wdata[2];  // bit 2 low selects write
					vertical   <= !cpu_wdata[3];  // bit 3 low is vertical mirroring
				end
				REG_DISK_SIDE: begin
					disk_side <= cpu_wdata[1:0];
				end
				default: begin
				end
			endcase
		end
	end

endmodule

/* rtl/fds_irq_timer.sv */
// disk system IRQ timer: reload counter ticking on bus strobes, one-shot or repeat
`timescale 1ns/1ps

module fds_irq_timer #(
	parameter int TIMER_W = 16
) (
	input  logic               clk20,
	input  logic               reset,
	input  logic               cpu_strobe,
	input  logic               cpu_we,
	input  fds_map_pkg::addr_t cpu_addr,
	input  logic [7:0]         cpu_wdata,
	input  logic               latch_lo_load,
	input  logic               latch_hi_load,
	input  logic               timer_ctrl_load,
	input  logic               disk_en_load,
	input  logic               disk_reg_en,
	output logic               irq
);
	import fds_map_pkg::*;

	logic [TIMER_W-1:0] latch;
	logic [TIMER_W-1:0] count;
	logic [15:0]        latch_ext;
	logic [15:0]        latch_next;
	logic               timer_en;
	logic               timer_repeat;
	logic               irq_ack;

	assign irq_ack   = cpu_strobe && !cpu_we && (cpu_addr == REG_IRQ_STAT);
	assign latch_ext = 16'(latch);

	// byte writes into the reload value
	always_comb begin
		latch_next = latch_ext;
		if (latch_lo_load)
			latch_next[7:0] = cpu_wdata;
		if (latch_hi_load)
			latch_next[15:8] = cpu_wdata;
	end

	always_ff @(posedge clk20) begin
		if (latch_lo_load || latch_hi_load)
			latch <= TIMER_W'(latch_next);
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			timer_en     <= 1'b0;
			timer_repeat <= 1'b0;
			irq          <= 1'b0;
			count        <= '0;
		end else if (cpu_strobe) begin
			if (timer_en) begin
				if (count == '0) begin
					irq   <= 1'b1;
					count <= latch;
					if (!timer_repeat)
						timer_en <= 1'b0;
				end else begin
					count <= count - 1'b1;
				end
			end
			// register writes override the tick of the same strobe
			if (timer_ctrl_load) begin
				timer_repeat <= cpu_wdata[0];
				timer_en     <= cpu_wdata[1] && disk_reg_en;
				if (cpu_wdata[1] && disk_reg_en)
					count <= latch;
				else
					irq <= 1'b0;
			end
			if (disk_en_load && !cpu_wdata[0]) begin
				timer_en <= 1'b0;
				irq      <= 1'b0;
			end
			if (irq_ack)
				irq <= 1'b0;  // status read acknowledges
		end
	end

	a_irq_off_after_disable: assert property (@(posedge clk20) disable iff (reset)
		disk_en_load && !cpu_wdata[0] |=> !irq);

endmodule

/* rtl/fds_disk_stream.sv */
// disk data stream: read/write port sequencers, disk position and image offset
`timescale 1ns/1ps

module fds_disk_stream (
	input  logic                      clk20,
	input  logic                      reset,
	input  logic                      cpu_strobe,
	input  logic                      cpu_we,
	input  fds_map_pkg::addr_t        cpu_addr,
	input  logic                      write_en,
	input  logic                      disk_reset,
	input  fds_disk_pkg::side_t       disk_side,
	output fds_disk_pkg::port_state_t rd_state,
	output fds_disk_pkg::port_state_t wr_state,
	output fds_disk_pkg::disk_off_t   disk_offset,
	output logic                      disk_end,
	output logic                      saved
);
	import fds_map_pkg::*;
	import fds_disk_pkg::*;

	disk_pos_t disk_pos;
	logic      rd_lo;
	logic      rd_hi;
	logic      wr_lo;
	logic      wr_hi;

	// low port arms, high port after low starts streaming, anything else drops back
	function automatic port_state_t seq_next(port_state_t cur, logic hit_lo, logic hit_hi);
		if (hit_lo)
			return ST_ARMED;
		if (hit_hi && cur == ST_ARMED)
			return ST_ACTIVE;
		return ST_IDLE;
	endfunction

	assign rd_lo = !cpu_we && (cpu_addr == PORT_READ_LO);
	assign rd_hi = !cpu_we && (cpu_addr == PORT_READ_HI);
	assign wr_lo = write_en && !cpu_we && (cpu_addr == PORT_WRITE_LO);
	assign wr_hi = write_en && !cpu_we && (cpu_addr == PORT_WRITE_HI);

	assign disk_end    = (disk_pos == disk_pos_t'(DISK_END));
	assign disk_offset = disk_off_t'(disk_pos) + side_offset(disk_side);

	always_ff @(posedge clk20) begin
		if (reset) begin
			rd_state <= ST_IDLE;
			wr_state <= ST_IDLE;
			saved    <= 1'b0;
			disk_pos <= '0;
		end else if (cpu_strobe) begin
			rd_state <= seq_next(rd_state, rd_lo, rd_hi);
			wr_state <= seq_next(wr_state, wr_lo, wr_hi);
			if (wr_state == ST_ACTIVE)
				saved <= 1'b1;  // sticky until reset
			if (disk_reset)
				disk_pos <= '0;
			else if (rd_state == ST_ACTIVE && !disk_end)
				disk_pos <= disk_pos + 1'b1;
		end
	end

	a_pos_in_side: assert property (@(posedge clk20) disable iff (reset)
		disk_pos <= disk_pos_t'(DISK_END));

endmodule

/* rtl/fds_prg_map.sv */
// disk system memory map: PRG banking and permission, CHR mirroring, register readback
`timescale 1ns/1ps

module fds_prg_map (
	input  fds_map_pkg::addr_t        cpu_addr,
	input  logic                      cpu_we,
	input  logic [13:0]               chr_ain,
	input  logic                      vertical,
	input  fds_disk_pkg::port_state_t rd_state,
	input  fds_disk_pkg::port_state_t wr_state,
	input  fds_disk_pkg::disk_off_t   disk_offset,
	input  logic                      disk_end,
	input  logic                      saved,
	input  logic                      irq,
	input  logic                      disk_swap,
	input  logic                      busy,
	output fds_map_pkg::prg_addr_t    prg_addr,
	output logic                      prg_allow,
	output fds_map_pkg::chr_addr_t    chr_addr,
	output logic                      ciram_ce,
	output logic [7:0]                cpu_rdata
);
	import fds_map_pkg::*;
	import fds_disk_pkg::*;

	logic       rd_active;
	logic       wr_active;
	logic       in_bios;     // E000-FFFF
	logic       in_ram_wr;   // 6000-DFFF
	logic       in_ram_rd;   // 6000-7FFF
	logic       port_lo;
	logic       port_hi;
	logic       eject;
	logic       nt_a10;
	logic [5:0] disk_bank;
	logic [5:0] prg_bank;

	assign rd_active = (rd_state == ST_ACTIVE);
	assign wr_active = (wr_state == ST_ACTIVE);
	assign in_bios   = (cpu_addr[15:13] == 3'b111);
	assign in_ram_wr = cpu_addr[15] ^ (&cpu_addr[14:13]);
	assign in_ram_rd = (cpu_addr[15:13] == 3'b011);
	assign eject     = disk_swap;  // eject straight from the swap input

	// offset bytes show on the ports only between streams
	assign port_lo = ((cpu_addr == PORT_READ_LO) || (cpu_addr == PORT_WRITE_LO))
		&& !(rd_active || wr_active);
	assign port_hi = ((cpu_addr == PORT_READ_HI) || (cpu_addr == PORT_WRITE_HI))
		&& !(rd_active || wr_active);

	assign disk_bank = {1'b1, disk_offset[17:13]};

	always_comb begin
		if (in_bios)
			prg_bank = (rd_active || wr_active) ? disk_bank : 6'd0;
		else
			prg_bank = {RAM_BANK_BASE, cpu_addr[14:13]};
	end

	assign prg_addr = {prg_bank, cpu_addr[12:0]};

	always_comb begin
		if (cpu_we)
			prg_allow = in_ram_wr || wr_active;
		else
			prg_allow = in_ram_rd || (cpu_addr[15] && !(in_bios && rd_active));
	end

	// nametable mirroring
	assign nt_a10   = vertical ? chr_ain[10] : chr_ain[11];
	assign ciram_ce = chr_ain[13];
	assign chr_addr = {6'd0, chr_ain[12:11], chr_ain[13] ? nt_a10 : chr_ain[10]};

	always_comb begin
		if (cpu_addr == REG_IRQ_STAT)
			cpu_rdata = {7'd0, irq};
		else if (cpu_addr == REG_DRIVE_STAT)
			cpu_rdata = {5'd0, eject, disk_end, eject};
		else if (cpu_addr == REG_EXP_STAT)
			cpu_rdata = 8'h80;  // power good
		else if (port_lo)
			cpu_rdata = disk_offset[7:0];
		else if (port_hi)
			cpu_rdata = {3'b111, disk_offset[12:8]};
		else if (cpu_addr == REG_SAVED)
			cpu_rdata = {7'd0, saved};
		else if (cpu_addr == REG_BUSY)
			cpu_rdata = {7'd0, !busy};  // zero while busy
		else
			cpu_rdata = 8'd0;
	end

endmodule

/* rtl/fds_mapper.sv */
// disk system mapper top: register control, IRQ timer, disk stream and memory map
`timescale 1ns/1ps

module fds_mapper #(
	parameter int TIMER_W = 16
) (
	input  logic                   clk20,
	input  logic                   reset,
	input  logic                   cpu_strobe,
	input  logic                   cpu_we,
	input  fds_map_pkg::addr_t     cpu_addr,
	input  logic [7:0]             cpu_wdata,
	input  logic [13:0]            chr_ain,
	input  logic                   disk_swap,
	input  logic                   busy,
	output logic [7:0]             cpu_rdata,
	output fds_map_pkg::prg_addr_t prg_addr,
	output logic                   prg_allow,
	output fds_map_pkg::chr_addr_t chr_addr,
	output logic                   ciram_ce,
	output logic                   irq,
	output fds_disk_pkg::side_t    disk_side
);
	import fds_disk_pkg::*;

	logic        latch_lo_load;
	logic        latch_hi_load;
	logic        timer_ctrl_load;
	logic        disk_en_load;
	logic        disk_reg_en;
	logic        disk_reset;
	logic        write_en;
	logic        vertical;
	port_state_t rd_state;
	port_state_t wr_state;
	disk_off_t   disk_offset;
	logic        disk_end;
	logic        saved;

	fds_reg_ctrl #(.TIMER_W(TIMER_W)) i_reg_ctrl (
		.clk20(clk20), .reset(reset), .cpu_strobe(cpu_strobe), .cpu_we(cpu_we),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.latch_lo_load(latch_lo_load), .latch_hi_load(latch_hi_load),
		.timer_ctrl_load(timer_ctrl_load), .disk_en_load(disk_en_load),
		.disk_reg_en(disk_reg_en), .disk_reset(disk_reset), .write_en(write_en),
		.vertical(vertical), .disk_side(disk_side)
	);

	fds_irq_timer #(.TIMER_W(TIMER_W)) i_irq_timer (
		.clk20(clk20), .reset(reset), .cpu_strobe(cpu_strobe), .cpu_we(cpu_we),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.latch_lo_load(latch_lo_load), .latch_hi_load(latch_hi_load),
		.timer_ctrl_load(timer_ctrl_load), .disk_en_load(disk_en_load),
		.disk_reg_en(disk_reg_en), .irq(irq)
	);

	fds_disk_stream i_disk_stream (
		.clk20(clk20), .reset(reset), .cpu_strobe(cpu_strobe), .cpu_we(cpu_we),
		.cpu_addr(cpu_addr), .write_en(write_en), .disk_reset(disk_reset),
		.disk_side(disk_side), .rd_state(rd_state), .wr_state(wr_state),
		.disk_offset(disk_offset), .disk_end(disk_end), .saved(saved)
	);

	fds_prg_map i_prg_map (
		.cpu_addr(cpu_addr), .cpu_we(cpu_we), .chr_ain(chr_ain), .vertical(vertical),
		.rd_state(rd_state), .wr_state(wr_state), .disk_offset(disk_offset),
		.disk_end(disk_end), .saved(saved), .irq(irq), .disk_swap(disk_swap),
		.busy(busy), .prg_addr(prg_addr), .prg_allow(prg_allow), .chr_addr(chr_addr),
		.ciram_ce(ciram_ce), .cpu_rdata(cpu_rdata)
	);

endmodule

/* sim/tb_fds_mapper.sv */
// disk system mapper testbench: bus stimulus, reference model and output assertions
`timescale 1ns/1ps

module tb_fds_mapper;
	import fds_map_pkg::*;
	import fds_disk_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_TIMER  = 6;
	localparam int NUM_STREAM = 24;
	localparam int NUM_MAP    = 200;
	localparam int NUM_MIRROR = 24;
	// three clocks per bus cycle and a timer loop sized for a latch of 63
	localparam int TEST_CYCLES = 3 * (NUM_TIMER * 480 + NUM_STREAM * 3 + NUM_MAP
		+ NUM_MIRROR + 20) + 2 * NUM_MIRROR + 16;

	logic        clk20 = 1'b0;
	logic        reset;
	logic        cpu_strobe;
	logic        cpu_we;
	addr_t       cpu_addr;
	logic [7:0]  cpu_wdata;
	logic [13:0] chr_ain;
	logic        disk_swap;
	logic        busy;
	logic [7:0]  cpu_rdata;
	prg_addr_t   prg_addr;
	logic        prg_allow;
	chr_addr_t   chr_addr;
	logic        ciram_ce;
	logic        irq;
	side_t       disk_side;

	// reference model state
	logic        exp_irq, exp_en, exp_rep, exp_reg_en;
	logic [15:0] exp_latch, exp_count, exp_pos;
	logic        exp_disk_rst, exp_wr_en, exp_vert, exp_saved;
	side_t       exp_side;
	port_state_t exp_rd, exp_wr;
	disk_off_t   exp_offset;
	logic        exp_active;
	prg_addr_t   exp_prg_addr;
	logic        exp_allow;
	logic [7:0]  exp_rdata;
	chr_addr_t   exp_chr_addr;
	logic [31:0] lfsr = 32'h3753_132a;
	int          errors = 0;

	fds_mapper #(.TIMER_W(16)) i_fds_mapper (.*);

	always #(CLK_PERIOD / 2) clk20 = ~clk20;

	// galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		int          i;
		val = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			val = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	// low port arms, high port after it streams, any other strobe drops to idle
	function automatic port_state_t port_next(port_state_t cur, logic lo, logic hi);
		if (lo)
			return ST_ARMED;
		return (hi && cur == ST_ARMED) ? ST_ACTIVE : ST_IDLE;
	endfunction

	always_ff @(posedge clk20) begin
		if (reset) begin
			exp_irq <= 1'b0;
			exp_en <= 1'b0;
			exp_rep <= 1'b0;
			exp_reg_en <= 1'b0;
			exp_latch <= '0;
			exp_count <= '0;
			exp_pos <= '0;
			exp_disk_rst <= 1'b0;
			exp_wr_en <= 1'b0;
			exp_vert <= 1'b0;
			exp_saved <= 1'b0;
			exp_side <= '0;
			exp_rd <= ST_IDLE;
			exp_wr <= ST_IDLE;
		end else if (cpu_strobe) begin
			if (exp_en && exp_count == 16'd0) begin
				exp_irq <= 1'b1;  // expiry reloads
				exp_count <= exp_latch;
				exp_en <= exp_rep;
			end else if (exp_en) begin
				exp_count <= exp_count - 16'd1;
			end
			if (cpu_we && cpu_addr == REG_TIMER_LO)
				exp_latch[7:0] <= cpu_wdata;
			if (cpu_we && cpu_addr == REG_TIMER_HI)
				exp_latch[15:8] <= cpu_wdata;
			if (cpu_we && cpu_addr == REG_TIMER_CTRL) begin
				exp_rep <= cpu_wdata[0];
				exp_en <= cpu_wdata[1] && exp_reg_en;
				if (cpu_wdata[1] && exp_reg_en)
					exp_count <= exp_latch;
				else
					exp_irq <= 1'b0;
			end
			if (cpu_we && cpu_addr == REG_DISK_EN) begin
				exp_reg_en <= cpu_wdata[0];
				if (!cpu_wdata[0]) begin
					exp_en <= 1'b0;
					exp_irq <= 1'b0;
				end
			end
			if (cpu_we && cpu_addr == REG_DISK_CTRL) begin
				exp_disk_rst <= cpu_wdata[1];
				exp_wr_en <= !cpu_wdata[2];
				exp_vert <= !cpu_wdata[3];
			end
			if (cpu_we && cpu_addr == REG_DISK_SIDE)
				exp_side <= cpu_wdata[1:0];
			if (!cpu_we && cpu_addr == REG_IRQ_STAT)
				exp_irq <= 1'b0;  // status read acknowledges
			exp_rd <= port_next(exp_rd, !cpu_we && cpu_addr == PORT_READ_LO,
				!cpu_we && cpu_addr == PORT_READ_HI);
			exp_wr <= port_next(exp_wr, exp_wr_en && !cpu_we && cpu_addr == PORT_WRITE_LO,
				exp_wr_en && !cpu_we && cpu_addr == PORT_WRITE_HI);
			if (exp_wr == ST_ACTIVE)
				exp_saved <= 1'b1;
			if (exp_disk_rst)
				exp_pos <= '0;
			else if (exp_rd == ST_ACTIVE && exp_pos != 16'(DISK_END))
				exp_pos <= exp_pos + 16'd1;
		end
	end

	always_comb begin
		int off_full;
		off_full = HEADER_BYTES + int'(exp_side) * SIDE_BYTES + int'(exp_pos);
		exp_offset = disk_off_t'(off_full);
		exp_active = (exp_rd == ST_ACTIVE) || (exp_wr == ST_ACTIVE);
		if (cpu_addr >= 16'hE000)
			exp_prg_addr = {exp_active ? {1'b1, exp_offset[17:13]} : 6'd0, cpu_addr[12:0]};
		else
			exp_prg_addr = {RAM_BANK_BASE, cpu_addr[14:0]};
		if (cpu_we)
			exp_allow = (cpu_addr >= 16'h6000 && cpu_addr <= 16'hDFFF) || exp_wr == ST_ACTIVE;
		else
			exp_allow = (cpu_addr >= 16'h6000 && cpu_addr <= 16'h7FFF) || (cpu_addr >= 16'h8000
				&& !(cpu_addr >= 16'hE000 && exp_rd == ST_ACTIVE));
		if (cpu_addr == REG_IRQ_STAT)
			exp_rdata = {7'd0, exp_irq};
		else if (cpu_addr == REG_DRIVE_STAT)
			exp_rdata = {5'd0, disk_swap, exp_pos == 16'(DISK_END), disk_swap};
		else if (cpu_addr == REG_EXP_STAT)
			exp_rdata = 8'h80;
		else if ((cpu_addr == PORT_READ_LO || cpu_addr == PORT_WRITE_LO) && !exp_active)
			exp_rdata = exp_offset[7:0];
		else if ((cpu_addr == PORT_READ_HI || cpu_addr == PORT_WRITE_HI) && !exp_active)
			exp_rdata = {3'b111, exp_offset[12:8]};
		else if (cpu_addr == REG_SAVED)
			exp_rdata = {7'd0, exp_saved};
		else if (cpu_addr == REG_BUSY)
			exp_rdata = {7'd0, !busy};
		else
			exp_rdata = 8'd0;
		exp_chr_addr = {6'd0, chr_ain[12:11],
			chr_ain[13] ? (exp_vert ? chr_ain[10] : chr_ain[11]) : chr_ain[10]};
	end

	task automatic flag_wrong_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		errors = errors + 1;
		$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
	endtask

	a_irq: assert property (@(posedge clk20) disable iff (reset) irq == exp_irq)
		else flag_wrong_value("irq", 32'($sampled(irq)), 32'($sampled(exp_irq)));
	a_side: assert property (@(posedge clk20) disable iff (reset) disk_side == exp_side)
		else flag_wrong_value("disk_side", 32'($sampled(disk_side)), 32'($sampled(exp_side)));
	a_rdata: assert property (@(posedge clk20) disable iff (reset) cpu_rdata == exp_rdata)
		else flag_wrong_value("cpu_rdata", 32'($sampled(cpu_rdata)), 32'($sampled(exp_rdata)));
	a_prg_addr: assert property (@(posedge clk20) disable iff (reset) prg_addr == exp_prg_addr)
		else flag_wrong_value("prg_addr", 32'($sampled(prg_addr)), 32'($sampled(exp_prg_addr)));
	a_prg_allow: assert property (@(posedge clk20) disable iff (reset) prg_allow == exp_allow)
		else flag_wrong_value("prg_allow", 32'($sampled(prg_allow)), 32'($sampled(exp_allow)));
	a_ciram: assert property (@(posedge clk20) disable iff (reset) ciram_ce == chr_ain[13])
		else flag_wrong_value("ciram_ce", 32'($sampled(ciram_ce)), 32'($sampled(chr_ain[13])));
	a_chr: assert property (@(posedge clk20) disable iff (reset) chr_addr == exp_chr_addr)
		else flag_wrong_value("chr_addr", 32'($sampled(chr_addr)), 32'($sampled(exp_chr_addr)));

	// one strobe, then two idle clocks
	task automatic bus_cycle(input logic we, input addr_t addr, input logic [7:0] data);
		cpu_strobe <= 1'b1;
		cpu_we <= we;
		cpu_addr <= addr;
		cpu_wdata <= data;
		@(posedge clk20);
		cpu_strobe <= 1'b0;
		cpu_we <= 1'b0;
		repeat (2) @(posedge clk20);
	endtask

	task automatic write_reg(input addr_t addr, input logic [7:0] data);
		bus_cycle(1'b1, addr, data);
	endtask

	task automatic read_reg(input addr_t addr);
		bus_cycle(1'b0, addr, 8'h00);
	endtask

	task automatic idle_strobes(input int count);
		repeat (count) read_reg(REG_EXP_STAT);
	endtask

	task automatic timer_test(input logic [15:0] n);
		write_reg(REG_DISK_EN, 8'h01);
		write_reg(REG_TIMER_LO, n[7:0]);
		write_reg(REG_TIMER_HI, n[15:8]);
		write_reg(REG_TIMER_CTRL, 8'h02);  // one-shot
		idle_strobes(int'(n) + 2);
		read_reg(REG_IRQ_STAT);
		idle_strobes(int'(n) + 2);
		write_reg(REG_TIMER_CTRL, 8'h03);  // repeat
		idle_strobes(int'(n) + 1);
		read_reg(REG_IRQ_STAT);
		idle_strobes(int'(n) + 1);
		write_reg(REG_TIMER_CTRL, 8'h00);
		write_reg(REG_TIMER_CTRL, 8'h03);
		idle_strobes(int'(n) + 1);
		write_reg(REG_DISK_EN, 8'h00);  // drops irq and stops the timer
		idle_strobes(int'(n) + 2);
	endtask

	task automatic stream_test(input int count);
		logic [31:0] r;
		write_reg(REG_DISK_CTRL, 8'h06);  // hold position at zero with write off
		write_reg(REG_DISK_SIDE, 8'(rand_bits(2)));
		write_reg(REG_DISK_CTRL, 8'h04);
		repeat (count) begin
			r = rand_bits(13);
			read_reg(PORT_READ_LO);
			read_reg(PORT_READ_HI);
			read_reg({3'b111, r[12:0]});
		end
		read_reg(PORT_READ_HI);
	endtask

	task automatic status_test();
		write_reg(REG_DISK_CTRL, 8'h00);  // write enabled
		read_reg(PORT_WRITE_LO);
		read_reg(PORT_WRITE_HI);
		write_reg(16'hE000, 8'h5a);
		read_reg(REG_SAVED);
		disk_swap <= 1'b1;
		read_reg(REG_DRIVE_STAT);
		disk_swap <= 1'b0;
		read_reg(REG_DRIVE_STAT);
		busy <= 1'b1;
		read_reg(REG_BUSY);
		busy <= 1'b0;
		read_reg(REG_BUSY);
	endtask

	initial begin
		logic [31:0] r;
		reset <= 1'b1;
		cpu_strobe <= 1'b0;
		cpu_we <= 1'b0;
		cpu_addr <= '0;
		cpu_wdata <= '0;
		chr_ain <= '0;
		disk_swap <= 1'b0;
		busy <= 1'b0;
		repeat (16) @(posedge clk20);
		reset <= 1'b0;
		@(posedge clk20);
		repeat (NUM_TIMER) timer_test(16'(rand_bits(6)));
		stream_test(NUM_STREAM);
		repeat (NUM_MAP) begin
			r = rand_bits(25);
			bus_cycle(r[24], r[15:0], r[23:16]);
		end
		status_test();
		repeat (NUM_MIRROR) begin
			r = rand_bits(29);
			write_reg(REG_DISK_CTRL, {4'd0, r[28], 3'b100});
			chr_ain <= r[13:0];
			@(posedge clk20);
			chr_ain <= r[27:14];
			@(posedge clk20);
		end
		@(posedge clk20);
		$display("Test sequence done with %0d errors", errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#((TEST_CYCLES + 500) * CLK_PERIOD);
		$display("Timeout: the test sequence did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

/* build.f */
rtl/fds_map_pkg.sv
rtl/fds_disk_pkg.sv
rtl/fds_reg_ctrl.sv
rtl/fds_irq_timer.sv
rtl/fds_disk_stream.sv
rtl/fds_prg_map.sv
rtl/fds_mapper.sv
sim/tb_fds_mapper.sv

/* Makefile */
TOP := tb_fds_mapper
SRCS := $(wildcard rtl/*.sv) $(wildcard sim/*.sv)

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

obj_dir/V$(TOP): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
